// File: doodleCtrl.sv
`timescale 1ns/10ps

module doodleCtrl import doodlePkg::*; (
	input logic Reset,
	input logic frame_clk,
	input logic frameTick,
	input logic [7:0] keycode,
	input logic floorHit,
	input logic [ScoreW-1:0] score,
	output logic [1:0] mode,
	output logic step,
	output logic restart
);

	logic [7:0] prevKey;	// key seen on the last frame tick
	logic startPress;
	logic pausePress;
	logic gameOver;
	logic [1:0] modeNext;
	logic startOk;

	// a press is a new key on this tick, so holding a key acts once
	assign startPress = frameTick && (keycode == KeyStart) && (prevKey != KeyStart);
	assign pausePress = frameTick && (keycode == KeyPause) && (prevKey != KeyPause);

	// floor reached after the grace score, decided on the step itself
	assign gameOver = step && floorHit && (score >= ScoreLimit);

	assign startOk = startPress && ((mode == ModeIdle) || (mode == ModeOver));

	always_comb
	begin
		modeNext = mode;
		unique case (mode)
			ModeIdle, ModeOver:
				if (startPress)
					modeNext = ModePlay;
			ModePlay:
			begin
				if (gameOver)
					modeNext = ModeOver;
				else if (pausePress)
					modeNext = ModePause;
			end
			ModePause:
				if (pausePress)
					modeNext = ModePlay;
		endcase
	end

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			mode <= ModeIdle;
			prevKey <= 8'd0;
			step <= 1'b0;
			restart <= 1'b0;
		end
		else
		begin
			mode <= modeNext;
			if (frameTick)
				prevKey <= keycode;
			// only frames that start and stay in play get stepped
			step <= frameTick && (mode == ModePlay) && (modeNext == ModePlay);
			restart <= startOk;
		end
	end

endmodule

// File: doodlePkg.sv
package doodlePkg;

	// datapath widths
	localparam int PosW = 10;
	localparam int ScoreW = 20;

	// screen geometry
	localparam int ScreenYMax = 479;	// floor line
	localparam int ScreenXMax = 639;
	localparam int WrapMargin = 25;
	localparam int WrapLow = 96;	// landing x after wrapping off the right side
	localparam int WrapHigh = 543;	// landing x after wrapping off the left side

	// object half sizes
	localparam int DoodleSize = 6;
	localparam int PlatHalfW = 20;
	localparam int PlatHalfH = 3;
	localparam int SpringHalf = 4;

	// physics, all per frame
	localparam int JumpSpeed = 12;
	localparam int SpringSpeed = 20;
	localparam int MaxFall = 8;
	localparam int XStep = 4;

	// start state
	localparam int StartX = 330;
	localparam int StartY = 300;
	localparam int ScoreLimit = 256;	// floor keeps bouncing below this score

	// keyboard codes
	localparam logic [7:0] KeyRight = 8'd7;
	localparam logic [7:0] KeyRightAlt = 8'd79;
	localparam logic [7:0] KeyLeft = 8'd4;
	localparam logic [7:0] KeyLeftAlt = 8'd80;
	localparam logic [7:0] KeyStart = 8'd40;
	localparam logic [7:0] KeyPause = 8'd19;

	// game modes
	localparam logic [1:0] ModeIdle = 2'd0;
	localparam logic [1:0] ModePlay = 2'd1;
	localparam logic [1:0] ModePause = 2'd2;
	localparam logic [1:0] ModeOver = 2'd3;

endpackage

// File: doodleTop.sv
`timescale 1ns/10ps

module doodleTop import doodlePkg::*; #(
	parameter int NumPlats = 16
) (
	input logic Reset,
	input logic frame_clk,
	input logic frameTick,
	input logic [7:0] keycode,
	input logic [NumPlats*PosW-1:0] platX,
	input logic [NumPlats*PosW-1:0] platY,
	input logic [NumPlats-1:0] platGone,
	input logic [PosW-1:0] springX,
	input logic [PosW-1:0] springY,
	output logic [PosW-1:0] doodleX,
	output logic [PosW-1:0] doodleY,
	output logic signed [PosW-1:0] velY,
	output logic [ScoreW-1:0] score,
	output logic [1:0] mode,
	output logic platLand
);

	logic step;
	logic restart;
	logic springLand;
	logic floorHit;

	// mode and frame strobes
	doodleCtrl ctrl0 (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.frameTick(frameTick),
		.keycode(keycode),
		.floorHit(floorHit),
		.score(score),
		.mode(mode),
		.step(step),
		.restart(restart)
	);

	platformHit #(
		.NumPlats(NumPlats)
	) hit0 (
		.doodleX(doodleX),
		.doodleY(doodleY),
		.platX(platX),
		.platY(platY),
		.platGone(platGone),
		.springX(springX),
		.springY(springY),
		.platLand(platLand),
		.springLand(springLand)
	);

	verticalMotion vert0 (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.step(step),
		.restart(restart),
		.platLand(platLand),
		.springLand(springLand),
		.doodleY(doodleY),
		.velY(velY),
		.floorHit(floorHit)
	);

	horizontalMotion horiz0 (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.step(step),
		.restart(restart),
		.keycode(keycode),
		.doodleX(doodleX)
	);

	scoreKeeper score0 (
		.Reset(Reset),
		.frame_clk(frame_clk),
		.step(step),
		.restart(restart),
		.doodleY(doodleY),
		.score(score)
	);

endmodule

// File: doodle_props.sv
`timescale 1ns/10ps

module doodleProps import doodlePkg::*; (
	input logic Reset,
	input logic frame_clk,
	input logic [1:0] mode,
	input logic step,
	input logic restart
);

	// the two frame strobes are exclusive
	noStrobeClash: assert property (@(posedge Reset) disable iff (frame_clk)
		!(step && restart))
		else $error("step and restart were high together");

	// physics only advances while playing
	stepInPlay: assert property (@(posedge Reset) disable iff (frame_clk)
		step |-> (mode == ModePlay))
		else $error("step seen outside play mode");

	// a finished game can only be restarted
	overExit: assert property (@(posedge Reset) disable iff (frame_clk)
		(mode == ModeOver) |=> ((mode == ModeOver) || (mode == ModePlay)))
		else $error("mode left over for something other than play");

endmodule

bind doodleCtrl doodleProps props0 (
	.Reset(Reset),
	.frame_clk(frame_clk),
	.mode(mode),
	.step(step),
	.restart(restart)
);

// File: horizontalMotion.sv
`timescale 1ns/10ps

module horizontalMotion import doodlePkg::*; (
	input logic Reset,
	input logic frame_clk,
	input logic step,
	input logic restart,
	input logic [7:0] keycode,
	output logic [PosW-1:0] doodleX
);

	logic nearRight;
	logic nearLeft;
	logic [PosW-1:0] xNext;

	assign nearRight = (int'(doodleX) + DoodleSize) >= (ScreenXMax - WrapMargin);
	assign nearLeft = int'(doodleX) <= (WrapMargin + DoodleSize);	// x - size <= margin

	always_comb
	begin
		if (nearRight)
			xNext = PosW'(WrapLow);
		else if (nearLeft)
			xNext = PosW'(WrapHigh);
		else
		begin
			unique case (keycode)
				KeyRight, KeyRightAlt:
					xNext = doodleX + PosW'(XStep);
				KeyLeft, KeyLeftAlt:
					xNext = doodleX - PosW'(XStep);
				default:
					xNext = doodleX;	// no steering key held
			endcase
		end
	end

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
			doodleX <= PosW'(StartX);
		else if (restart)
			doodleX <= PosW'(StartX);
		else if (step)
			doodleX <= xNext;
	end

endmodule

// File: platformHit.sv
`timescale 1ns/10ps

module platformHit import doodlePkg::*; #(
	parameter int NumPlats = 16
) (
	input logic [PosW-1:0] doodleX,
	input logic [PosW-1:0] doodleY,
	input logic [NumPlats*PosW-1:0] platX,
	input logic [NumPlats*PosW-1:0] platY,
	input logic [NumPlats-1:0] platGone,
	input logic [PosW-1:0] springX,
	input logic [PosW-1:0] springY,
	output logic platLand,
	output logic springLand
);

	// feet against an object of the given half sizes centred at (ox, oy)
	function automatic logic landsOn(
		input logic [PosW-1:0] dx0,
		input logic [PosW-1:0] dy0,
		input logic [PosW-1:0] ox,
		input logic [PosW-1:0] oy,
		input int halfW,
		input int halfH
	);
		int feet;
		int dx;
		int dy;
		feet = int'(dy0) + DoodleSize;
		dx = int'(dx0) - int'(ox);
		dy = feet - int'(oy);
		return (dy <= halfH) && (dy >= -halfH) &&
			(dx <= halfW + DoodleSize) && (dx >= -(halfW + DoodleSize));
	endfunction

	always_comb
	begin
		platLand = 1'b0;
		for (int i = 0; i < NumPlats; i++)
		begin
			if (!platGone[i] && landsOn(doodleX, doodleY, platX[i*PosW +: PosW],
					platY[i*PosW +: PosW], PlatHalfW, PlatHalfH))
				platLand = 1'b1;
		end
	end

	// spring is square, same half size both ways
	assign springLand = landsOn(doodleX, doodleY, springX, springY, SpringHalf, SpringHalf);

endmodule

// File: scoreKeeper.sv
`timescale 1ns/10ps

module scoreKeeper import doodlePkg::*; (
	input logic Reset,
	input logic frame_clk,
	input logic step,
	input logic restart,
	input logic [PosW-1:0] doodleY,
	output logic [ScoreW-1:0] score
);

	logic [PosW-1:0] bestY;	// highest point so far, smaller y is higher
	logic newHigh;
	logic [PosW-1:0] gain;

	assign newHigh = doodleY < bestY;
	assign gain = bestY - doodleY;

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			bestY <= PosW'(StartY);
			score <= '0;
		end
		else if (restart)
		begin
			bestY <= PosW'(StartY);
			score <= '0;
		end
		else if (step && newHigh)
		begin
			// only fresh height is paid for
			score <= score + ScoreW'(gain);
			bestY <= doodleY;
		end
	end

endmodule

// File: src.f
doodlePkg.sv
doodleCtrl.sv
platformHit.sv
verticalMotion.sv
horizontalMotion.sv
scoreKeeper.sv
doodleTop.sv
doodle_props.sv
tb_doodle.sv

// File: tb_doodle.sv
`timescale 1ns/10ps

module tb_doodle import doodlePkg::*; ();

	localparam int Plats = 4;
	localparam int CycleLimit = 4000;

	logic Reset;	// clock
	logic frame_clk;	// reset
	logic frameTick;
	logic [7:0] keycode;
	logic [Plats*PosW-1:0] platXBus;
	logic [Plats*PosW-1:0] platYBus;
	logic [Plats-1:0] platGoneBus;
	logic [PosW-1:0] springX;
	logic [PosW-1:0] springY;
	logic [PosW-1:0] doodleX;
	logic [PosW-1:0] doodleY;
	logic signed [PosW-1:0] velY;
	logic [ScoreW-1:0] score;
	logic [1:0] mode;
	logic platLand;

	int errCount = 0;
	int cycles = 0;
	// reference model state
	int mX, mY, mV, mBest, mScore, sX, sY;
	int pX [Plats];
	int pY [Plats];
	bit pGone [Plats];
	logic [1:0] mMode;
	logic [7:0] prevK;
	int bounceKind;	// 0 none, 1 platform, 2 spring, 3 floor
	int wrapKind;	// 0 none, 1 to low side, 2 to high side

	doodleTop #(.NumPlats(Plats)) dut0 (
		.Reset(Reset), .frame_clk(frame_clk), .frameTick(frameTick), .keycode(keycode),
		.platX(platXBus), .platY(platYBus), .platGone(platGoneBus),
		.springX(springX), .springY(springY), .doodleX(doodleX), .doodleY(doodleY),
		.velY(velY), .score(score), .mode(mode), .platLand(platLand)
	);

	initial
	begin
		Reset = 1'b0;
		forever #2 Reset = ~Reset;
	end

	always @(posedge Reset)
	begin
		cycles <= cycles + 1;
		if (cycles >= CycleLimit)
		begin
			$display("timeout: the tests did not finish within %0d cycles", CycleLimit);
			$display("SIMULATION FAILED");
			$finish;
		end
	end

	function automatic bit touches(int x, int y, int ox, int oy, int hw, int hh);
		int dx;
		int dy;
		dx = x - ox;
		dy = y + DoodleSize - oy;
		return (dy <= hh) && (dy >= -hh) && (dx <= hw + DoodleSize) && (dx >= -(hw + DoodleSize));
	endfunction

	// any active platform under the feet of the model position
	function automatic bit platUnderFeet();
		bit hit;
		hit = 0;
		for (int i = 0; i < Plats; i++)
			if (!pGone[i] && touches(mX, mY, pX[i], pY[i], PlatHalfW, PlatHalfH))
				hit = 1;
		return hit;
	endfunction

	task automatic checkValue(string what, int got, int exp);
		assert (got == exp)
		else
		begin
			errCount++;
			$display("[FAIL] %0t %s: got %0d, expected %0d", $time, what, got, exp);
		end
	endtask

	task automatic expectEvent(bit happened, string what);
		assert (happened)
		else
		begin
			errCount++;
			$display("%s did not happen", what);
		end
	endtask

	task automatic checkAll();
		checkValue("x", doodleX, mX);
		checkValue("y", doodleY, mY);
		checkValue("vy", $signed(velY), mV);
		checkValue("score", score, mScore);
		checkValue("mode", mode, mMode);
		checkValue("platLand", platLand, platUnderFeet());
	endtask

	task automatic resetModel();
		mX = StartX;
		mY = StartY;
		mV = 0;
		mBest = StartY;
		mScore = 0;
	endtask

	// one frame of the game rules applied to the model
	task automatic modelFrame(logic [7:0] key);
		bit startP, pauseP, doStep, over, pl, sp, fl;
		int newV;
		startP = (key == KeyStart) && (prevK != KeyStart);
		pauseP = (key == KeyPause) && (prevK != KeyPause);
		prevK = key;
		doStep = 0;
		bounceKind = 0;
		wrapKind = 0;
		case (mMode)
			ModeIdle, ModeOver:
				if (startP)
				begin
					mMode = ModePlay;
					resetModel();
				end
			ModePlay:
				if (pauseP)
					mMode = ModePause;
				else
					doStep = 1;
			default:
				if (pauseP)
					mMode = ModePlay;
		endcase
		if (doStep)
		begin
			fl = (mY + DoodleSize) >= ScreenYMax;
			over = fl && (mScore >= ScoreLimit);
			pl = platUnderFeet();
			sp = touches(mX, mY, sX, sY, SpringHalf, SpringHalf);
			if (mY < mBest)
			begin
				mScore += mBest - mY;
				mBest = mY;
			end
			if (mX + DoodleSize >= ScreenXMax - WrapMargin)
			begin
				mX = WrapLow;
				wrapKind = 1;
			end
			else if (mX - DoodleSize <= WrapMargin)
			begin
				mX = WrapHigh;
				wrapKind = 2;
			end
			else if (key == KeyRight || key == KeyRightAlt)
				mX += XStep;
			else if (key == KeyLeft || key == KeyLeftAlt)
				mX -= XStep;
			if (mV >= 0 && sp)
			begin
				newV = -SpringSpeed;
				bounceKind = 2;
			end
			else if (mV >= 0 && (pl || fl))
			begin
				newV = -JumpSpeed;
				bounceKind = pl ? 1 : 3;
			end
			else
				newV = (mV >= MaxFall) ? MaxFall : mV + 1;
			mY = (mY + mV) & 10'h3ff;	// 10 bit position wraps
			mV = newV;
			if (over)
				mMode = ModeOver;
		end
	endtask

	task automatic placeObjects();
		@(posedge Reset);
		for (int i = 0; i < Plats; i++)
		begin
			platXBus[i*PosW +: PosW] <= PosW'(pX[i]);
			platYBus[i*PosW +: PosW] <= PosW'(pY[i]);
			platGoneBus[i] <= pGone[i];
		end
		springX <= PosW'(sX);
		springY <= PosW'(sY);
	endtask

	task automatic clearObjects();
		for (int i = 0; i < Plats; i++)
			pGone[i] = 1;
		sX = 10;	// far corner, never reached
		sY = 10;
		placeObjects();
	endtask

	// tick, then wait for the two cycle latency and compare
	task automatic doFrame(logic [7:0] key);
		modelFrame(key);
		@(posedge Reset);
		frameTick <= 1'b1;
		keycode <= key;
		@(posedge Reset);
		frameTick <= 1'b0;
		@(posedge Reset);
		@(posedge Reset);
		@(negedge Reset);
		checkAll();
	endtask

	task automatic testReset();
		logic [7:0] k;
		checkAll();
		repeat (5)
		begin
			k = $urandom % 256;
			if (k == KeyStart || k == KeyPause)
				k = 8'd0;
			doFrame(k);
		end
	endtask

	task automatic testFreeFall();
		bit sawFloor;
		sawFloor = 0;
		doFrame(KeyStart);
		repeat (45)
		begin
			doFrame(8'd0);
			if (bounceKind == 3)
			begin
				sawFloor = 1;
				checkValue("vy after floor", $signed(velY), -JumpSpeed);
			end
		end
		expectEvent(sawFloor, "a floor bounce");
	endtask

	// put an object under the feet of the next step, then wait for the bounce
	task automatic landOnObject(bit useSpring);
		bit seen;
		seen = 0;
		for (int n = 0; n < 40 && mV < 4; n++)
			doFrame(8'd0);
		pGone[0] = 0;
		pX[0] = mX;
		pY[0] = mY + mV + DoodleSize;
		if (useSpring)
		begin
			sX = mX;
			sY = pY[0];
		end
		placeObjects();
		for (int n = 0; n < 5 && !seen; n++)
		begin
			doFrame(8'd0);
			if (bounceKind == (useSpring ? 2 : 1))
				seen = 1;
		end
		expectEvent(seen, "the expected landing");
		checkValue("vy after landing", $signed(velY), useSpring ? -SpringSpeed : -JumpSpeed);
		clearObjects();
	endtask

	task automatic testSideways();
		bit seen;
		seen = 0;
		for (int n = 0; n < 100 && !seen; n++)
		begin
			doFrame(KeyRight);
			seen = (wrapKind == 1);
		end
		expectEvent(seen, "a wrap to the left side");
		seen = 0;
		for (int n = 0; n < 100 && !seen; n++)
		begin
			doFrame(KeyLeft);
			seen = (wrapKind == 2);
		end
		expectEvent(seen, "a wrap to the right side");
	endtask

	task automatic testPause();
		doFrame(8'd0);
		doFrame(KeyPause);
		checkValue("mode paused", mode, ModePause);
		repeat (3)
			doFrame(KeyPause);	// held key toggles only once
		doFrame(8'd0);
		doFrame(KeyPause);
		checkValue("mode resumed", mode, ModePlay);
		repeat (3)
			doFrame(8'd0);
	endtask

	task automatic testScoreAndOver();
		for (int n = 0; n < 120 && mScore < ScoreLimit; n++)
		begin
			sX = (mV >= 1) ? mX : 10;
			sY = (mV >= 1) ? mY + mV + DoodleSize : 10;
			placeObjects();
			doFrame(8'd0);
		end
		clearObjects();
		for (int n = 0; n < 120 && mMode != ModeOver; n++)
			doFrame(8'd0);
		checkValue("mode over", mode, ModeOver);
		repeat (3)
			doFrame(KeyRight);
		doFrame(KeyStart);
		checkValue("score after restart", score, 0);
		checkValue("mode after restart", mode, ModePlay);
	endtask

	initial
	begin
		void'($urandom(33));
		frame_clk = 1'b1;
		frameTick = 1'b0;
		keycode = 8'd0;
		platXBus = '0;
		platYBus = '0;
		platGoneBus = '1;
		springX = 10;
		springY = 10;
		for (int i = 0; i < Plats; i++)
		begin
			pGone[i] = 1;
			pX[i] = 0;
			pY[i] = 0;
		end
		sX = 10;
		sY = 10;
		resetModel();
		mMode = ModeIdle;
		prevK = 8'd0;
		repeat (3) @(posedge Reset);
		frame_clk <= 1'b0;
		@(negedge Reset);
		testReset();
		testFreeFall();
		landOnObject(0);
		landOnObject(1);
		testSideways();
		testPause();
		testScoreAndOver();
		$display("errors: %0d", errCount);
		if (errCount == 0)
			$display("SIMULATION PASSED");
		else
			$display("SIMULATION FAILED");
		$finish;
	end

endmodule

// File: verticalMotion.sv
`timescale 1ns/10ps

module verticalMotion import doodlePkg::*; (
	input logic Reset,
	input logic frame_clk,
	input logic step,
	input logic restart,
	input logic platLand,
	input logic springLand,
	output logic [PosW-1:0] doodleY,
	output logic signed [PosW-1:0] velY,
	output logic floorHit
);

	logic falling;
	logic signed [PosW-1:0] velNext;

	assign floorHit = (int'(doodleY) + DoodleSize) >= ScreenYMax;
	assign falling = (velY >= 0);	// zero counts as falling

	// spring wins over a plain bounce
	always_comb
	begin
		if (falling && springLand)
			velNext = -PosW'(SpringSpeed);
		else if (falling && (platLand || floorHit))
			velNext = -PosW'(JumpSpeed);
		else if (velY >= MaxFall)
			velNext = PosW'(MaxFall);	// terminal speed
		else
			velNext = velY + PosW'(1);	// gravity
	end

	always_ff @(posedge Reset or posedge frame_clk)
	begin
		if (frame_clk)
		begin
			doodleY <= PosW'(StartY);
			velY <= '0;
		end
		else if (restart)
		begin
			doodleY <= PosW'(StartY);
			velY <= '0;
		end
		else if (step)
		begin
			doodleY <= doodleY + $unsigned(velY);	// position uses the old speed
			velY <= velNext;
		end
	end

endmodule
